/* list.f */
+incdir+sim
rtl/decode_pkg.sv
rtl/rv64i_decoder.sv
rtl/imm_gen.sv
rtl/uop_fifo.sv
rtl/decode_ctrl.sv
rtl/decode_top.sv
sim/decode_tb.sv

/* rtl/decode_ctrl.sv */
// decode control
// run and halt state, queue pointers and count, stall, push, pop and flush
// plus assertions on the queue occupancy and the halt
`timescale 1ns/1ns
`default_nettype none

module decode_ctrl
	import decode_pkg::*;
(
	input  logic              clk,
	input  logic              rst,
	input  logic              fetch_valid,
	input  logic              issue_pop,
	input  logic              flush,
	input  uop_op_e           wr_op,
	output logic              wr_en,
	output logic [UOP_AW-1:0] wr_ptr,
	output logic [UOP_AW-1:0] rd_ptr,
	output logic              fetch_stall,
	output logic              issue_valid
);

	ctrl_state_e state;
	logic [UOP_CNT_W-1:0] count;
	logic full;
	logic pop_en;

	assign full = (count == UOP_CNT_W'(UOP_DEPTH));
	assign issue_valid = (count != '0);
	assign fetch_stall = full | (state == ST_HALT);

	// take an instruction only when there is room and we are not halted
	assign wr_en = fetch_valid & ~fetch_stall;
	assign pop_en = issue_pop & issue_valid;

	always_ff @(posedge clk) begin
		if (rst || flush) begin
			state <= ST_RUN;
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (wr_en)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop_en)
				rd_ptr <= rd_ptr + 1'b1;
			case ({wr_en, pop_en})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
			// illegal op is queued, then nothing more until a flush
			if (wr_en && wr_op == OP_ILLEGAL)
				state <= ST_HALT;
		end
	end

	// a full queue never advances the write pointer
	a_no_write_full: assert property (@(posedge clk) disable iff (rst)
		(full && !flush) |=> $stable(wr_ptr));

	a_count_range: assert property (@(posedge clk) disable iff (rst)
		count <= UOP_CNT_W'(UOP_DEPTH));

	// once halted, the halt and the write pointer hold until a flush
	a_halt_no_write: assert property (@(posedge clk) disable iff (rst)
		(state == ST_HALT && !flush) |=> (state == ST_HALT) && $stable(wr_ptr));

endmodule

`default_nettype wire

/* rtl/decode_pkg.sv */
// shared definitions for the decode stage
// widths, queue sizing, major opcodes, micro-op and format enums,
// ctrl states and the micro-op struct
`default_nettype none

package decode_pkg;

	// data and address width
	localparam int XLEN = 64;

	// micro-op queue sizing
	localparam int UOP_DEPTH = 4;
	localparam int UOP_AW = 2;
	// count needs one more bit than the pointers to hold a full queue
	localparam int UOP_CNT_W = UOP_AW + 1;

	// major opcodes, bits [6:0] of a 32-bit instruction
	localparam logic [6:0] OPC_LOAD = 7'b0000011;
	localparam logic [6:0] OPC_MISC_MEM = 7'b0001111;
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
	localparam logic [6:0] OPC_AUIPC = 7'b0010111;
	localparam logic [6:0] OPC_OP_IMM32 = 7'b0011011;
	localparam logic [6:0] OPC_STORE = 7'b0100011;
	localparam logic [6:0] OPC_OP = 7'b0110011;
	localparam logic [6:0] OPC_LUI = 7'b0110111;
	localparam logic [6:0] OPC_OP32 = 7'b0111011;
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;
	localparam logic [6:0] OPC_JALR = 7'b1100111;
	localparam logic [6:0] OPC_JAL = 7'b1101111;
	localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

	// micro-op opcode, one member per supported instruction
	typedef enum logic [5:0] {
		OP_ILLEGAL,
		// upper immediate and jumps
		OP_LUI, OP_AUIPC, OP_JAL, OP_JALR,
		// branches
		OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU,
		// loads
		OP_LB, OP_LH, OP_LW, OP_LD, OP_LBU, OP_LHU, OP_LWU,
		// stores
		OP_SB, OP_SH, OP_SW, OP_SD,
		// register-immediate
		OP_ADDI, OP_SLTI, OP_SLTIU, OP_XORI, OP_ORI, OP_ANDI,
		OP_SLLI, OP_SRLI, OP_SRAI,
		OP_ADDIW, OP_SLLIW, OP_SRLIW, OP_SRAIW,
		// register-register
		OP_ADD, OP_SUB, OP_SLL, OP_SLT, OP_SLTU,
		OP_XOR, OP_SRL, OP_SRA, OP_OR, OP_AND,
		OP_ADDW, OP_SUBW, OP_SLLW, OP_SRLW, OP_SRAW,
		// memory ordering
		OP_FENCE, OP_FENCE_I,
		// system and csr
		OP_ECALL, OP_EBREAK,
		OP_CSRRW, OP_CSRRS, OP_CSRRC,
		OP_CSRRWI, OP_CSRRSI, OP_CSRRCI
	} uop_op_e;

	// which immediate layout to extract
	typedef enum logic [2:0] {
		IMM_NONE,
		IMM_I,
		IMM_S,
		IMM_B,
		IMM_U,
		IMM_J
	} imm_fmt_e;

	// decode control state
	typedef enum logic {
		ST_RUN,
		ST_HALT
	} ctrl_state_e;

	// one decoded instruction, 156 bits
	typedef struct packed {
		logic is_rvc;
		uop_op_e op;
		logic [XLEN-1:0] pc;
		logic [XLEN-1:0] imm;
		logic [5:0] shamt;
		logic [4:0] rd;
		logic [4:0] rs1;
		logic [4:0] rs2;
	} decode_uop_t;

endpackage

`default_nettype wire

/* rtl/decode_top.sv */
// decode stage top level
// decoder, immediate generator, micro-op queue and control
`timescale 1ns/1ns
`default_nettype none

module decode_top
	import decode_pkg::*;
(
	input  logic            clk,
	input  logic            rst,
	input  logic [31:0]     instr,
	input  logic [XLEN-1:0] pc,
	input  logic            fetch_valid,
	input  logic            flush,
	input  logic            issue_pop,
	output logic            fetch_stall,
	output logic            issue_valid,
	output decode_uop_t     issue_uop
);

	uop_op_e dec_op;
	imm_fmt_e dec_imm_fmt;
	logic [5:0] dec_shamt;
	logic [4:0] dec_rd;
	logic [4:0] dec_rs1;
	logic [4:0] dec_rs2;
	logic [XLEN-1:0] dec_imm;
	decode_uop_t wr_uop;
	logic wr_en;
	logic [UOP_AW-1:0] wr_ptr;
	logic [UOP_AW-1:0] rd_ptr;

	rv64i_decoder u_decoder (
		.instr   (instr),
		.op      (dec_op),
		.imm_fmt (dec_imm_fmt),
		.shamt   (dec_shamt),
		.rd      (dec_rd),
		.rs1     (dec_rs1),
		.rs2     (dec_rs2)
	);

	imm_gen u_imm_gen (
		.instr   (instr),
		.imm_fmt (dec_imm_fmt),
		.imm     (dec_imm)
	);

	// compressed instructions are not decoded, so is_rvc stays low
	always_comb begin
		wr_uop.is_rvc = 1'b0;
		wr_uop.op = dec_op;
		wr_uop.pc = pc;
		wr_uop.imm = dec_imm;
		wr_uop.shamt = dec_shamt;
		wr_uop.rd = dec_rd;
		wr_uop.rs1 = dec_rs1;
		wr_uop.rs2 = dec_rs2;
	end

	uop_fifo u_fifo (
		.clk    (clk),
		.wr_en  (wr_en),
		.wr_ptr (wr_ptr),
		.wr_uop (wr_uop),
		.rd_ptr (rd_ptr),
		.rd_uop (issue_uop)
	);

	decode_ctrl u_ctrl (
		.clk         (clk),
		.rst         (rst),
		.fetch_valid (fetch_valid),
		.issue_pop   (issue_pop),
		.flush       (flush),
		.wr_op       (wr_uop.op),
		.wr_en       (wr_en),
		.wr_ptr      (wr_ptr),
		.rd_ptr      (rd_ptr),
		.fetch_stall (fetch_stall),
		.issue_valid (issue_valid)
	);

endmodule

`default_nettype wire

/* rtl/imm_gen.sv */
// immediate generator
// I, S, B, U and J immediates, sign extended from instr[31]
`timescale 1ns/1ns
`default_nettype none

module imm_gen
	import decode_pkg::*;
(
	input  logic [31:0]     instr,
	input  imm_fmt_e        imm_fmt,
	output logic [XLEN-1:0] imm
);

	logic sign;

	assign sign = instr[31];

	always_comb begin
		case (imm_fmt)
			IMM_I: imm = {{(XLEN-12){sign}}, instr[31:20]};
			IMM_S: imm = {{(XLEN-12){sign}}, instr[31:25], instr[11:7]};
			// branch offsets are in units of two bytes
			IMM_B: begin
				imm = {{(XLEN-13){sign}}, instr[31], instr[7], instr[30:25],
					instr[11:8], 1'b0};
			end
			IMM_U: imm = {{(XLEN-32){sign}}, instr[31:12], 12'b0};
			IMM_J: begin
				imm = {{(XLEN-21){sign}}, instr[31], instr[19:12], instr[20],
					instr[30:21], 1'b0};
			end
			default: imm = '0;
		endcase
	end

endmodule

`default_nettype wire

/* rtl/rv64i_decoder.sv */
// rv64i instruction decoder
// major opcode, funct3 and funct7 into a micro-op opcode,
// an immediate format and the register fields
`timescale 1ns/1ns
`default_nettype none

module rv64i_decoder
	import decode_pkg::*;
(
	input  logic [31:0] instr,
	output uop_op_e     op,
	output imm_fmt_e    imm_fmt,
	output logic [5:0]  shamt,
	output logic [4:0]  rd,
	output logic [4:0]  rs1,
	output logic [4:0]  rs2
);

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic [11:0] funct12;

	assign opcode = instr[6:0];
	assign funct3 = instr[14:12];
	assign funct7 = instr[31:25];
	assign funct12 = instr[31:20];

	// register fields pass straight through, zimm of csr*i sits in rs1
	assign rd = instr[11:7];
	assign rs1 = instr[19:15];
	assign rs2 = instr[24:20];
	// 6-bit shamt for the 64-bit shifts
	assign shamt = instr[25:20];

	always_comb begin
		op = OP_ILLEGAL;
		imm_fmt = IMM_NONE;
		case (opcode)
			OPC_LUI: begin
				op = OP_LUI;
				imm_fmt = IMM_U;
			end
			OPC_AUIPC: begin
				op = OP_AUIPC;
				imm_fmt = IMM_U;
			end
			OPC_JAL: begin
				op = OP_JAL;
				imm_fmt = IMM_J;
			end
			OPC_JALR: begin
				imm_fmt = IMM_I;
				if (funct3 == 3'b000)
					op = OP_JALR;
			end
			OPC_BRANCH: begin
				imm_fmt = IMM_B;
				case (funct3)
					3'b000: op = OP_BEQ;
					3'b001: op = OP_BNE;
					3'b100: op = OP_BLT;
					3'b101: op = OP_BGE;
					3'b110: op = OP_BLTU;
					3'b111: op = OP_BGEU;
					default: op = OP_ILLEGAL;
				endcase
			end
			OPC_LOAD: begin
				imm_fmt = IMM_I;
				case (funct3)
					3'b000: op = OP_LB;
					3'b001: op = OP_LH;
					3'b010: op = OP_LW;
					3'b011: op = OP_LD;
					3'b100: op = OP_LBU;
					3'b101: op = OP_LHU;
					3'b110: op = OP_LWU;
					default: op = OP_ILLEGAL;
				endcase
			end
			OPC_STORE: begin
				imm_fmt = IMM_S;
				case (funct3)
					3'b000: op = OP_SB;
					3'b001: op = OP_SH;
					3'b010: op = OP_SW;
					3'b011: op = OP_SD;
					default: op = OP_ILLEGAL;
				endcase
			end
			OPC_OP_IMM: begin
				imm_fmt = IMM_I;
				case (funct3)
					3'b000: op = OP_ADDI;
					3'b010: op = OP_SLTI;
					3'b011: op = OP_SLTIU;
					3'b100: op = OP_XORI;
					3'b110: op = OP_ORI;
					3'b111: op = OP_ANDI;
					// shamt[5] lives in funct7[0], so only the top six bits select
					3'b001: if (funct7[6:1] == 6'b000000) op = OP_SLLI;
					3'b101: begin
						if (funct7[6:1] == 6'b000000)
							op = OP_SRLI;
						else if (funct7[6:1] == 6'b010000)
							op = OP_SRAI;
					end
					default: op = OP_ILLEGAL;
				endcase
			end
			OPC_OP_IMM32: begin
				imm_fmt = IMM_I;
				case ({funct7, funct3})
					{7'b0000000, 3'b001}: op = OP_SLLIW;
					{7'b0000000, 3'b101}: op = OP_SRLIW;
					{7'b0100000, 3'b101}: op = OP_SRAIW;
					default: if (funct3 == 3'b000) op = OP_ADDIW;
				endcase
			end
			OPC_OP: begin
				case ({funct7, funct3})
					{7'b0000000, 3'b000}: op = OP_ADD;
					{7'b0100000, 3'b000}: op = OP_SUB;
					{7'b0000000, 3'b001}: op = OP_SLL;
					{7'b0000000, 3'b010}: op = OP_SLT;
					{7'b0000000, 3'b011}: op = OP_SLTU;
					{7'b0000000, 3'b100}: op = OP_XOR;
					{7'b0000000, 3'b101}: op = OP_SRL;
					{7'b0100000, 3'b101}: op = OP_SRA;
					{7'b0000000, 3'b110}: op = OP_OR;
					{7'b0000000, 3'b111}: op = OP_AND;
					default: op = OP_ILLEGAL;
				endcase
			end
			OPC_OP32: begin
				case ({funct7, funct3})
					{7'b0000000, 3'b000}: op = OP_ADDW;
					{7'b0100000, 3'b000}: op = OP_SUBW;
					{7'b0000000, 3'b001}: op = OP_SLLW;
					{7'b0000000, 3'b101}: op = OP_SRLW;
					{7'b0100000, 3'b101}: op = OP_SRAW;
					default: op = OP_ILLEGAL;
				endcase
			end
			OPC_MISC_MEM: begin
				imm_fmt = IMM_I;
				if (funct3 == 3'b000)
					op = OP_FENCE;
				else if (funct3 == 3'b001)
					op = OP_FENCE_I;
			end
			OPC_SYSTEM: begin
				// csr address rides in the I immediate
				imm_fmt = IMM_I;
				case (funct3)
					3'b000: begin
						imm_fmt = IMM_NONE;
						if (funct12 == 12'h000)
							op = OP_ECALL;
						else if (funct12 == 12'h001)
							op = OP_EBREAK;
					end
					3'b001: op = OP_CSRRW;
					3'b010: op = OP_CSRRS;
					3'b011: op = OP_CSRRC;
					3'b101: op = OP_CSRRWI;
					3'b110: op = OP_CSRRSI;
					3'b111: op = OP_CSRRCI;
					default: op = OP_ILLEGAL;
				endcase
			end
			default: op = OP_ILLEGAL;
		endcase
		// an illegal micro-op always carries a zero immediate
		if (op == OP_ILLEGAL)
			imm_fmt = IMM_NONE;
	end

endmodule

`default_nettype wire

/* rtl/uop_fifo.sv */
// micro-op queue storage
// written at wr_ptr on the clock edge, read at rd_ptr combinationally
`timescale 1ns/1ns
`default_nettype none

module uop_fifo
	import decode_pkg::*;
(
	input  logic              clk,
	input  logic              wr_en,
	input  logic [UOP_AW-1:0] wr_ptr,
	input  decode_uop_t       wr_uop,
	input  logic [UOP_AW-1:0] rd_ptr,
	output decode_uop_t       rd_uop
);

	// entry validity is tracked by the pointers and count in ctrl
	decode_uop_t mem [UOP_DEPTH];

	always_ff @(posedge clk) begin
		if (wr_en)
			mem[wr_ptr] <= wr_uop;
	end

	// head is visible the cycle after the write edge
	assign rd_uop = mem[rd_ptr];

endmodule

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the decode stage testbench with verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ns \
	-f list.f --top-module decode_tb -o decode_sim

./obj_dir/decode_sim 2>&1 | tee sim.log

# verdict comes from the last lines of the log
if grep -q "Done: no errors" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi

/* sim/decode_vectors.svh */
// instruction table for the decode stage testbench
// one legal instruction per row, plus an undefined encoding for the halt test
`ifndef DECODE_VECTORS_SVH
`define DECODE_VECTORS_SVH

typedef struct packed {
	logic [31:0] instr;
	logic [XLEN-1:0] pc;
	uop_op_e op;
	logic [4:0] rd;
	logic [4:0] rs1;
	logic [4:0] rs2;
	logic [5:0] shamt;
	logic [XLEN-1:0] imm;
} vec_t;

localparam int NUM_VECS = 22;

// columns: instr, pc, op, rd, rs1, rs2, shamt, imm
// rd, rs1, rs2 and shamt are the raw fields [11:7], [19:15], [24:20], [25:20]
localparam vec_t VECS [NUM_VECS] = '{
	'{32'h002081B3, 64'h8000_0000, OP_ADD, 5'd3, 5'd1, 5'd2, 6'h02, 64'h0},
	'{32'h407302B3, 64'h8000_0004, OP_SUB, 5'd5, 5'd6, 5'd7, 6'h07, 64'h0},
	'{32'h40C5D53B, 64'h8000_0008, OP_SRAW, 5'd10, 5'd11, 5'd12, 6'h0C, 64'h0},
	'{32'hFFF00093, 64'h8000_000C, OP_ADDI, 5'd1, 5'd0, 5'd31, 6'h3F, '1},
	'{32'h01013403, 64'h8000_0010, OP_LD, 5'd8, 5'd2, 5'd16, 6'h10, 64'h10},
	'{32'h43F2D213, 64'h8000_0014, OP_SRAI, 5'd4, 5'd5, 5'd31, 6'h3F, 64'h43F},
	'{32'h01F2119B, 64'h8000_0018, OP_SLLIW, 5'd3, 5'd4, 5'd31, 6'h1F, 64'h1F},
	'{32'hFFC300E7, 64'h8000_001C, OP_JALR, 5'd1, 5'd6, 5'd28, 6'h3C, -64'sd4},
	'{32'hFE913C23, 64'h8000_0020, OP_SD, 5'd24, 5'd2, 5'd9, 6'h29, -64'sd8},
	'{32'h00208463, 64'h8000_0024, OP_BEQ, 5'd8, 5'd1, 5'd2, 6'h02, 64'h8},
	'{32'hFE4198E3, 64'h8000_0028, OP_BNE, 5'd17, 5'd3, 5'd4, 6'h24, -64'sd16},
	'{32'h123453B7, 64'h8000_002C, OP_LUI, 5'd7, 5'd8, 5'd3, 6'h23, 64'h1234_5000},
	'{32'h80000117, 64'h8000_0030, OP_AUIPC, 5'd2, 5'd0, 5'd0, 6'h00,
		64'hFFFF_FFFF_8000_0000},
	'{32'h001000EF, 64'h8000_0034, OP_JAL, 5'd1, 5'd0, 5'd1, 6'h01, 64'h800},
	'{32'hFFDFF06F, 64'hFFFF_FFFF_FFFF_FFF0, OP_JAL, 5'd0, 5'd31, 5'd29, 6'h3D, -64'sd4},
	'{32'h0FF0000F, 64'h8000_003C, OP_FENCE, 5'd0, 5'd0, 5'd31, 6'h3F, 64'hFF},
	'{32'h0000100F, 64'h8000_0040, OP_FENCE_I, 5'd0, 5'd0, 5'd0, 6'h00, 64'h0},
	'{32'h00000073, 64'h8000_0044, OP_ECALL, 5'd0, 5'd0, 5'd0, 6'h00, 64'h0},
	'{32'h00100073, 64'h8000_0048, OP_EBREAK, 5'd0, 5'd0, 5'd1, 6'h01, 64'h0},
	'{32'h300312F3, 64'h8000_004C, OP_CSRRW, 5'd5, 5'd6, 5'd0, 6'h00, 64'h300},
	'{32'hF142E0F3, 64'h8000_0050, OP_CSRRSI, 5'd1, 5'd5, 5'd20, 6'h14, -64'sd236},
	'{32'h340FF073, 64'h8000_0054, OP_CSRRCI, 5'd0, 5'd31, 5'd0, 6'h00, 64'h340}
};

// mul x1, x2, x3 belongs to the M extension, which is not decoded
localparam vec_t ILLEGAL_VEC =
	'{32'h023100B3, 64'h8000_0100, OP_ILLEGAL, 5'd1, 5'd2, 5'd3, 6'h23, 64'h0};

`endif

/* sim/decode_tb.sv */
// testbench for the decode stage
// table run with random pops, back-pressure, illegal halt and flush,
// scoreboard of expected micro-ops and the closing count line
`timescale 1ns/1ns
`default_nettype none

module decode_tb
	import decode_pkg::*;
();

	localparam int TIMEOUT = 50;

	logic clk;
	logic rst;
	logic [31:0] instr;
	logic [XLEN-1:0] pc;
	logic fetch_valid;
	logic flush;
	logic issue_pop;
	logic fetch_stall;
	logic issue_valid;
	decode_uop_t issue_uop;

	decode_uop_t expected_q [$];
	integer seed;
	int errors;
	int checks;

	`include "decode_vectors.svh"

	decode_top DUT (
		.clk         (clk),
		.rst         (rst),
		.instr       (instr),
		.pc          (pc),
		.fetch_valid (fetch_valid),
		.flush       (flush),
		.issue_pop   (issue_pop),
		.fetch_stall (fetch_stall),
		.issue_valid (issue_valid),
		.issue_uop   (issue_uop)
	);

	always #20 clk = ~clk;

	function automatic logic random_bit();
		logic [31:0] r;
		r = $random(seed);
		return r[0];
	endfunction

	function automatic decode_uop_t expected_uop(input vec_t v);
		decode_uop_t u;
		u.is_rvc = 1'b0;
		u.op = v.op;
		u.pc = v.pc;
		u.imm = v.imm;
		u.shamt = v.shamt;
		u.rd = v.rd;
		u.rs1 = v.rs1;
		u.rs2 = v.rs2;
		return u;
	endfunction

	task automatic expect_true(input logic cond, input string what);
		checks++;
		assert (cond) else begin
			errors++;
			$display("Error: %0t ns: %s", $time, what);
		end
	endtask

	task automatic check_head(input decode_uop_t exp);
		checks++;
		assert (issue_uop == exp) else begin
			errors++;
			$display("Error: %0t ns: wrong micro-op at the queue head", $time);
			$display("  got      op %0d pc %h imm %h rd %0d rs1 %0d rs2 %0d shamt %h",
				issue_uop.op, issue_uop.pc, issue_uop.imm, issue_uop.rd,
				issue_uop.rs1, issue_uop.rs2, issue_uop.shamt);
			$display("  expected op %0d pc %h imm %h rd %0d rs1 %0d rs2 %0d shamt %h",
				exp.op, exp.pc, exp.imm, exp.rd, exp.rs1, exp.rs2, exp.shamt);
		end
	endtask

	task automatic finish_run();
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	endtask

	task automatic report_timeout(input string what);
		errors++;
		$display("%s, at %0t ns", what, $time);
	endtask

	// outputs are settled at the falling edge, so check the head before driving
	task automatic run_cycle(input logic push, input vec_t v, input logic pop,
		output logic taken);
		@(negedge clk);
		if (pop && issue_valid) begin
			expect_true(expected_q.size() != 0, "queue popped an entry never pushed");
			if (expected_q.size() != 0)
				check_head(expected_q.pop_front());
		end
		taken = push && !fetch_stall;
		if (taken)
			expected_q.push_back(expected_uop(v));
		fetch_valid = push;
		instr = v.instr;
		pc = v.pc;
		issue_pop = pop;
	endtask

	// fetch holds the instruction until the stage takes it
	task automatic offer_until_taken(input vec_t v, input logic random_pops);
		logic taken;
		int waited;
		taken = 1'b0;
		waited = 0;
		while (!taken && waited < TIMEOUT) begin
			run_cycle(1'b1, v, random_pops && random_bit(), taken);
			waited++;
		end
		if (!taken)
			report_timeout("fetch_stall never released while offering an instruction");
	endtask

	task automatic drain_queue(input logic random_pops);
		logic taken;
		int waited;
		waited = 0;
		while ((expected_q.size() != 0 || issue_valid) && waited < TIMEOUT) begin
			run_cycle(1'b0, VECS[0], !random_pops || random_bit(), taken);
			waited++;
		end
		if (expected_q.size() != 0 || issue_valid)
			report_timeout("queue did not drain, micro-ops were lost or stuck");
	endtask

	// flush wins over the push and pop offered at the same edge
	task automatic flush_queue(input vec_t v);
		@(negedge clk);
		flush = 1'b1;
		fetch_valid = 1'b1;
		instr = v.instr;
		pc = v.pc;
		issue_pop = 1'b1;
		@(negedge clk);
		expect_true(!issue_valid && !fetch_stall, "queue or stall not cleared by flush");
		expected_q.delete();
		flush = 1'b0;
		fetch_valid = 1'b0;
		issue_pop = 1'b0;
	endtask

	initial begin
		int i;
		logic taken;
		seed = 32'h4ce9_8189;
		errors = 0;
		checks = 0;
		clk = 1'b0;
		rst = 1'b1;
		instr = '0;
		pc = '0;
		fetch_valid = 1'b0;
		flush = 1'b0;
		issue_pop = 1'b0;
		repeat (2) @(negedge clk);
		rst = 1'b0;
		@(negedge clk);
		expect_true(!issue_valid && !fetch_stall, "issue_valid or fetch_stall high after reset");

		// every instruction class, random pops
		for (i = 0; i < NUM_VECS; i++)
			offer_until_taken(VECS[i], 1'b1);
		drain_queue(1'b1);

		// back-pressure: fill the queue with pops held off
		for (i = 0; i < UOP_DEPTH; i++)
			offer_until_taken(VECS[i], 1'b0);
		for (i = 0; i < 3; i++) begin
			run_cycle(1'b1, VECS[UOP_DEPTH], 1'b0, taken);
			expect_true(!taken, "instruction taken while the queue is full");
		end
		drain_queue(1'b0);

		// undefined encoding is queued, then decode halts
		offer_until_taken(VECS[1], 1'b0);
		offer_until_taken(ILLEGAL_VEC, 1'b0);
		drain_queue(1'b0);
		for (i = 0; i < 4; i++) begin
			run_cycle(1'b1, VECS[2], 1'b0, taken);
			expect_true(fetch_stall, "fetch_stall dropped after an illegal op");
			expect_true(!issue_valid, "entry queued while halted");
		end

		// flush out of the halt, then flush a partly filled queue
		flush_queue(VECS[3]);
		offer_until_taken(VECS[5], 1'b0);
		offer_until_taken(VECS[6], 1'b0);
		flush_queue(VECS[7]);

		// decoding resumes after the flush
		for (i = 0; i < NUM_VECS; i++)
			offer_until_taken(VECS[i], 1'b1);
		drain_queue(1'b1);
		finish_run();
	end

endmodule

`default_nettype wire
